// ==== src/icache_pkg.sv ====
package icache_pkg;

  // memory command on the cache to memory bus
  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } bus_cmd_t;

  localparam int ADDR_BITS = 64;
  localparam int WORD_BITS = 64; // one line holds one instruction word

  // memory transaction tags, 0 means no tag
  localparam int MEM_TAG_BITS = 4;
  localparam int NUM_MEM_TAGS = 2 ** MEM_TAG_BITS - 1;

  // address fields of a fetch: | tag | index | offset |
  localparam int DECODE_TOP = 15;  // highest decoded address bit
  localparam int OFFSET_BITS = 3;  // byte within a word

  // upper half of a memory word is its address xor this
  localparam logic [31:0] DATA_XOR = 32'h5a5a_5a5a;

  // line tag width for a given index width
  function automatic int line_tag_bits(input int idx_bits);
    return DECODE_TOP + 1 - OFFSET_BITS - idx_bits;
  endfunction

endpackage

// ==== src/icache_array.sv ====
`timescale 1ns/1ps

module icache_array #(
  parameter int NUM_LINES = 32,
  localparam int IDX_BITS = $clog2(NUM_LINES),
  localparam int TAG_BITS = icache_pkg::line_tag_bits(IDX_BITS)
) (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic [IDX_BITS-1:0]              i_idx,
  input  logic [TAG_BITS-1:0]              i_tag,
  input  logic                             i_in_window,
  input  logic                             i_hit,
  input  logic [IDX_BITS-1:0]              i_tail,
  input  logic                             i_fill,
  input  logic [IDX_BITS-1:0]              i_fill_idx,
  input  logic [icache_pkg::WORD_BITS-1:0] i_fill_data,
  input  logic [IDX_BITS-1:0]              i_check_idx,
  output logic [icache_pkg::WORD_BITS-1:0] o_data,
  output logic                             o_valid,
  output logic [TAG_BITS-1:0]              o_tag_at_idx,
  output logic [TAG_BITS-1:0]              o_tag_at_tail,
  output logic [TAG_BITS-1:0]              o_tag_at_check
);

  logic [TAG_BITS-1:0]              tags  [NUM_LINES];
  logic [NUM_LINES-1:0]             valids;
  logic [icache_pkg::WORD_BITS-1:0] data  [NUM_LINES];

  // lookup at the fetch index
  assign o_data         = data[i_idx];
  assign o_valid        = valids[i_idx] && i_hit;
  assign o_tag_at_idx   = tags[i_idx];
  assign o_tag_at_tail  = tags[i_tail];   // tail request address
  assign o_tag_at_check = tags[i_check_idx]; // is a returning line still wanted

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int i = 0; i < NUM_LINES; i++) begin
        tags[i] <= '0;
      end
      valids <= '0;
    end else begin
      if (i_fill) begin
        valids[i_fill_idx] <= 1'b1;
      end
      tags[i_idx] <= i_tag;
      // later assignments win over a fill at the same index
      if (i_in_window && !i_hit) begin
        valids[i_idx] <= 1'b0; // conflict inside the window
      end
      if (!i_in_window) begin
        // window restarts here and the line is fetched again
        valids[i_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_fill) begin
      data[i_fill_idx] <= i_fill_data;
    end
  end

endmodule

// ==== src/mem_tag_table.sv ====
`timescale 1ns/1ps

module mem_tag_table #(
  parameter int NUM_LINES = 32,
  localparam int IDX_BITS = $clog2(NUM_LINES),
  localparam int TAG_BITS = icache_pkg::line_tag_bits(IDX_BITS)
) (
  input  logic                                i_clock,
  input  logic                                i_reset,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] i_response,
  input  logic [IDX_BITS-1:0]                 i_req_idx,
  input  logic [TAG_BITS-1:0]                 i_req_tag,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] i_data_tag,
  input  logic [icache_pkg::WORD_BITS-1:0]    i_data,
  input  logic [TAG_BITS-1:0]                 i_tag_at_check,
  output logic [IDX_BITS-1:0]                 o_check_idx,
  output logic                                o_fill,
  output logic [IDX_BITS-1:0]                 o_fill_idx,
  output logic [icache_pkg::WORD_BITS-1:0]    o_fill_data
);

  import icache_pkg::*;

  // one entry per usable memory tag, tag 0 has none
  logic [NUM_MEM_TAGS:1] ent_valid;
  logic [IDX_BITS-1:0]   ent_idx [1:NUM_MEM_TAGS];
  logic [TAG_BITS-1:0]   ent_tag [1:NUM_MEM_TAGS];
  logic                  returning;

  assign returning   = (i_data_tag != '0);
  assign o_check_idx = ent_idx[i_data_tag];

  // fill only if the line at that index still carries the requested tag
  assign o_fill      = returning && ent_valid[i_data_tag]
                       && (ent_tag[i_data_tag] == i_tag_at_check);
  assign o_fill_idx  = o_check_idx;
  assign o_fill_data = i_data;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      ent_valid <= '0;
    end else begin
      if (returning) begin
        ent_valid[i_data_tag] <= 1'b0; // retired, filled or dropped
      end
      if (i_response != '0) begin
        ent_valid[i_response] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_response != '0) begin
      ent_idx[i_response] <= i_req_idx;
      ent_tag[i_response] <= i_req_tag;
    end
  end

endmodule

// ==== src/prefetch_window.sv ====
`timescale 1ns/1ps

module prefetch_window #(
  parameter int NUM_LINES = 32,
  localparam int IDX_BITS = $clog2(NUM_LINES),
  localparam int TAG_BITS = icache_pkg::line_tag_bits(IDX_BITS)
) (
  input  logic                                i_clock,
  input  logic                                i_reset,
  input  logic [icache_pkg::ADDR_BITS-1:0]    i_proc_addr,
  input  logic [TAG_BITS-1:0]                 i_line_tag_at_idx,
  input  logic [TAG_BITS-1:0]                 i_line_tag_at_tail,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] i_response,
  output logic [IDX_BITS-1:0]                 o_idx,
  output logic [IDX_BITS-1:0]                 o_tail,
  output logic                                o_in_window,
  output logic                                o_hit,
  output logic [IDX_BITS-1:0]                 o_req_idx,
  output logic [TAG_BITS-1:0]                 o_req_tag,
  output icache_pkg::bus_cmd_t                o_mem_command,
  output logic [icache_pkg::ADDR_BITS-1:0]    o_mem_addr
);

  import icache_pkg::*;

  logic [IDX_BITS-1:0] head;
  logic [IDX_BITS-1:0] tail;
  logic [IDX_BITS-1:0] tail_plus_one;
  logic [IDX_BITS-1:0] idx;
  logic [TAG_BITS-1:0] tag;
  logic [IDX_BITS-1:0] dist_idx;
  logic [IDX_BITS-1:0] dist_tail;

  assign idx = i_proc_addr[OFFSET_BITS +: IDX_BITS];
  assign tag = i_proc_addr[DECODE_TOP -: TAG_BITS];

  // distances wrap modulo NUM_LINES
  assign tail_plus_one = tail + 1'b1;
  assign dist_idx      = idx - head;
  assign dist_tail     = tail - head;

  assign o_in_window = (dist_idx <= dist_tail);
  assign o_hit       = o_in_window && (i_line_tag_at_idx == tag);
  assign o_idx       = idx;
  assign o_tail      = tail;

  always_comb begin
    if (o_hit) begin
      // prefetch the tail line
      o_req_idx  = tail;
      o_req_tag  = i_line_tag_at_tail;
      o_mem_addr = '0;
      o_mem_addr[DECODE_TOP:0] = {i_line_tag_at_tail, tail, {OFFSET_BITS{1'b0}}};
    end else begin
      o_req_idx  = idx;
      o_req_tag  = tag;
      o_mem_addr = i_proc_addr; // demand fetch
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      head          <= '0;
      tail          <= '0;
      o_mem_command <= BUS_NONE;
    end else begin
      o_mem_command <= BUS_LOAD;
      if (o_hit) begin
        // grow only on an accepted load, never onto the head
        if (i_response != '0 && tail_plus_one != head) begin
          tail <= tail_plus_one;
        end
      end else begin
        head <= idx;
        tail <= idx;
      end
    end
  end

endmodule

// ==== src/tagged_memory.sv ====
`timescale 1ns/1ps

module tagged_memory #(
  parameter int MEM_LATENCY = 6
) (
  input  logic                                i_clock,
  input  logic                                i_reset,
  input  icache_pkg::bus_cmd_t                i_command,
  input  logic [icache_pkg::ADDR_BITS-1:0]    i_addr,
  output logic [icache_pkg::MEM_TAG_BITS-1:0] o_response,
  output logic [icache_pkg::WORD_BITS-1:0]    o_data,
  output logic [icache_pkg::MEM_TAG_BITS-1:0] o_data_tag
);

  import icache_pkg::*;

  localparam int LINE_BITS = DECODE_TOP + 1 - OFFSET_BITS;

  logic [NUM_MEM_TAGS:1]    free_mask;
  logic [MEM_TAG_BITS-1:0]  grant;
  logic [MEM_TAG_BITS-1:0]  pipe_tag  [MEM_LATENCY];
  logic [LINE_BITS-1:0]     pipe_line [MEM_LATENCY];
  logic [31:0]              word_addr;

  // lowest free tag, 0 when all are in flight
  always_comb begin
    grant = '0;
    for (int t = NUM_MEM_TAGS; t >= 1; t--) begin
      if (free_mask[t]) begin
        grant = MEM_TAG_BITS'(t);
      end
    end
  end

  assign o_response = (i_command == BUS_LOAD) ? grant : '0;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      free_mask <= '1;
    end else begin
      if (o_data_tag != '0) begin
        free_mask[o_data_tag] <= 1'b1;
      end
      if (o_response != '0) begin
        free_mask[o_response] <= 1'b0;
      end
    end
  end

  // return pipeline, stage 0 loaded in the accept cycle
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int s = 0; s < MEM_LATENCY; s++) begin
        pipe_tag[s] <= '0;
      end
    end else begin
      pipe_tag[0] <= o_response;
      for (int s = 1; s < MEM_LATENCY; s++) begin
        pipe_tag[s] <= pipe_tag[s-1];
      end
    end
  end

  always_ff @(posedge i_clock) begin
    pipe_line[0] <= i_addr[DECODE_TOP:OFFSET_BITS]; // only decoded bits kept
    for (int s = 1; s < MEM_LATENCY; s++) begin
      pipe_line[s] <= pipe_line[s-1];
    end
  end

  assign o_data_tag = pipe_tag[MEM_LATENCY-1];

  // word data is a function of its aligned address
  assign word_addr = 32'({pipe_line[MEM_LATENCY-1], {OFFSET_BITS{1'b0}}});
  assign o_data    = {word_addr ^ DATA_XOR, word_addr};

endmodule

// ==== src/icache_top.sv ====
`timescale 1ns/1ps

module icache_top #(
  parameter int NUM_LINES   = 32,
  parameter int MEM_LATENCY = 6
) (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic [icache_pkg::ADDR_BITS-1:0] i_proc_addr,
  output logic [icache_pkg::WORD_BITS-1:0] o_inst_data,
  output logic                             o_inst_valid
);

  import icache_pkg::*;

  localparam int IDX_BITS = $clog2(NUM_LINES);
  localparam int TAG_BITS = line_tag_bits(IDX_BITS);

  logic [IDX_BITS-1:0]     idx;
  logic [IDX_BITS-1:0]     tail;
  logic [IDX_BITS-1:0]     req_idx;
  logic [IDX_BITS-1:0]     check_idx;
  logic [IDX_BITS-1:0]     fill_idx;
  logic [TAG_BITS-1:0]     tag_at_idx;
  logic [TAG_BITS-1:0]     tag_at_tail;
  logic [TAG_BITS-1:0]     tag_at_check;
  logic [TAG_BITS-1:0]     req_tag;
  logic                    in_window;
  logic                    hit;
  logic                    fill;
  logic [WORD_BITS-1:0]    fill_data;
  logic [WORD_BITS-1:0]    mem_data;
  logic [MEM_TAG_BITS-1:0] response;
  logic [MEM_TAG_BITS-1:0] data_tag;
  bus_cmd_t                mem_command;
  logic [ADDR_BITS-1:0]    mem_addr;

  prefetch_window #(.NUM_LINES(NUM_LINES)) u_window (
    .i_clock            (i_clock),
    .i_reset            (i_reset),
    .i_proc_addr        (i_proc_addr),
    .i_line_tag_at_idx  (tag_at_idx),
    .i_line_tag_at_tail (tag_at_tail),
    .i_response         (response),
    .o_idx              (idx),
    .o_tail             (tail),
    .o_in_window        (in_window),
    .o_hit              (hit),
    .o_req_idx          (req_idx),
    .o_req_tag          (req_tag),
    .o_mem_command      (mem_command),
    .o_mem_addr         (mem_addr)
  );

  icache_array #(.NUM_LINES(NUM_LINES)) u_array (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_idx          (idx),
    .i_tag          (i_proc_addr[DECODE_TOP -: TAG_BITS]), // fetch tag
    .i_in_window    (in_window),
    .i_hit          (hit),
    .i_tail         (tail),
    .i_fill         (fill),
    .i_fill_idx     (fill_idx),
    .i_fill_data    (fill_data),
    .i_check_idx    (check_idx),
    .o_data         (o_inst_data),
    .o_valid        (o_inst_valid),
    .o_tag_at_idx   (tag_at_idx),
    .o_tag_at_tail  (tag_at_tail),
    .o_tag_at_check (tag_at_check)
  );

  mem_tag_table #(.NUM_LINES(NUM_LINES)) u_table (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_response     (response),
    .i_req_idx      (req_idx),
    .i_req_tag      (req_tag),
    .i_data_tag     (data_tag),
    .i_data         (mem_data),
    .i_tag_at_check (tag_at_check),
    .o_check_idx    (check_idx),
    .o_fill         (fill),
    .o_fill_idx     (fill_idx),
    .o_fill_data    (fill_data)
  );

  tagged_memory #(.MEM_LATENCY(MEM_LATENCY)) u_mem (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_command  (mem_command),
    .i_addr     (mem_addr),
    .o_response (response),
    .o_data     (mem_data),
    .o_data_tag (data_tag)
  );

endmodule

// ==== testbench/icache_properties.sv ====
`timescale 1ns/1ps

module icache_properties #(
  parameter int MEM_LATENCY = 6
) (
  input  logic                                i_clock,
  input  logic                                i_reset,
  input  icache_pkg::bus_cmd_t                i_command,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] i_response,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] i_data_tag
);

  import icache_pkg::*;

  logic [2**MEM_TAG_BITS-1:0] in_flight; // bit 0 unused since tag 0 is no tag
  int                         fail_count = 0; // failed assertions so far

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      in_flight <= '0;
    end else begin
      if (i_data_tag != '0) begin
        in_flight[i_data_tag] <= 1'b0;
      end
      if (i_response != '0) begin
        in_flight[i_response] <= 1'b1;
      end
    end
  end

  // data comes back a fixed number of cycles after its grant
  return_latency: assert property (@(posedge i_clock) disable iff (i_reset)
    (i_data_tag != '0) |-> (i_data_tag == $past(i_response, MEM_LATENCY)))
    else begin
      $error("tag %0d returned without a grant %0d cycles earlier", i_data_tag, MEM_LATENCY);
      fail_count++;
    end

  no_regrant: assert property (@(posedge i_clock) disable iff (i_reset)
    (i_response != '0) |-> !in_flight[i_response])
    else begin
      $error("tag %0d granted again while still in flight", i_response);
      fail_count++;
    end

  idle_no_grant: assert property (@(posedge i_clock)
    (i_command == BUS_NONE) |-> (i_response == '0))
    else begin
      $error("tag %0d granted without a load command", i_response);
      fail_count++;
    end

endmodule

// ==== testbench/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

  import icache_pkg::*;

  localparam int NUM_LINES    = 32;
  localparam int MEM_LATENCY  = 6;
  localparam int RESET_CYCLES = 4;
  localparam int VALID_BOUND  = MEM_LATENCY + 8;
  localparam int NUM_ENTRIES  = 21;
  localparam logic [31:0] RANDOM_SEED = 32'h3739_54a2;

  // what the first cycle of an entry should show
  localparam logic [1:0] EXPECT_MISS = 2'd0;
  localparam logic [1:0] EXPECT_HIT  = 2'd1;
  localparam logic [1:0] EXPECT_ANY  = 2'd2;

  logic                 clock;
  logic                 reset;
  logic [ADDR_BITS-1:0] proc_addr;
  logic [WORD_BITS-1:0] inst_data;
  logic                 inst_valid;

  logic [ADDR_BITS-1:0] tbl_addr   [NUM_ENTRIES];
  int                   tbl_hold   [NUM_ENTRIES];
  logic [1:0]           tbl_expect [NUM_ENTRIES];
  logic                 table_ready;
  int                   watchdog_cycles;

  icache_top #(.NUM_LINES(NUM_LINES), .MEM_LATENCY(MEM_LATENCY)) uut (
    .i_clock      (clock),
    .i_reset      (reset),
    .i_proc_addr  (proc_addr),
    .o_inst_data  (inst_data),
    .o_inst_valid (inst_valid)
  );

  bind tagged_memory icache_properties #(.MEM_LATENCY(MEM_LATENCY)) u_properties (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_command  (i_command),
    .i_response (o_response),
    .i_data_tag (o_data_tag)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // word at byte address A is {A xor 5a5a_5a5a, A} over the low 32 bits
  function automatic logic [WORD_BITS-1:0] expected_word(input logic [ADDR_BITS-1:0] addr);
    return {addr[31:0] ^ 32'h5a5a_5a5a, addr[31:0]};
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "run stopped after an error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    // cold miss held long enough for the window to run ahead
    tbl_addr[0]   = 64'h40;
    tbl_hold[0]   = 20;
    tbl_expect[0] = EXPECT_MISS;
    for (int k = 1; k <= 8; k++) begin
      tbl_addr[k]   = 64'h40 + 64'(8 * k); // prefetched lines
      tbl_hold[k]   = 2;
      tbl_expect[k] = EXPECT_HIT;
    end
    tbl_addr[9]   = 64'h140; // same index as 0x40 with another tag
    tbl_hold[9]   = 4;
    tbl_expect[9] = EXPECT_MISS;
    tbl_addr[10]   = 64'h40;
    tbl_hold[10]   = 4;
    tbl_expect[10] = EXPECT_MISS;
    for (int k = 11; k < NUM_ENTRIES; k++) begin
      rnd           = $urandom();
      tbl_addr[k]   = {48'h0, rnd[15:3], 3'b000};
      tbl_hold[k]   = 3;
      tbl_expect[k] = EXPECT_ANY;
    end
    watchdog_cycles = RESET_CYCLES;
    for (int k = 0; k < NUM_ENTRIES; k++) begin
      watchdog_cycles = watchdog_cycles + tbl_hold[k] + MEM_LATENCY + 20;
    end
  endtask

  // starts on a falling edge and returns on one
  task automatic apply_entry(input int n);
    logic [ADDR_BITS-1:0] addr;
    logic [WORD_BITS-1:0] want;
    int                   waited;
    addr      = tbl_addr[n];
    want      = expected_word(addr);
    waited    = 0;
    proc_addr = addr;
    #1;
    if (tbl_expect[n] == EXPECT_HIT) begin
      check_value("o_inst_valid", 64'(inst_valid), 64'd1);
    end else if (tbl_expect[n] == EXPECT_MISS) begin
      check_value("o_inst_valid", 64'(inst_valid), 64'd0);
    end
    while (inst_valid !== 1'b1) begin
      if (waited >= VALID_BOUND) begin
        $display("instruction never became valid for address %h within %0d cycles",
                 addr, VALID_BOUND);
        abort_run();
      end
      @(negedge clock);
      #1;
      waited++;
    end
    check_value("o_inst_data", inst_data, want);
    repeat (tbl_hold[n]) begin
      @(negedge clock);
      #1;
      check_value("o_inst_valid", 64'(inst_valid), 64'd1); // stays valid while held
      check_value("o_inst_data", inst_data, want);
    end
    @(negedge clock);
  endtask

  initial begin
    reset       = 1'b1;
    proc_addr   = '0;
    table_ready = 1'b0;
    void'($urandom(RANDOM_SEED));
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int n = 0; n < NUM_ENTRIES; n++) begin
      apply_entry(n);
    end
    if (uut.u_mem.u_properties.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("memory protocol assertions failed during the run");
      abort_run();
    end
  end

  // a failed protocol assertion ends the run at once
  initial begin
    wait (uut.u_mem.u_properties.fail_count != 0);
    $display("a memory protocol assertion failed at time %0t", $time);
    abort_run();
  end

  initial begin
    wait (table_ready === 1'b1);
    repeat (watchdog_cycles) @(posedge clock);
    $display("watchdog timeout, the stimulus table did not finish in %0d cycles",
             watchdog_cycles);
    abort_run();
  end

endmodule

// ==== files.f ====
src/icache_pkg.sv
src/icache_array.sv
src/mem_tag_table.sv
src/prefetch_window.sv
src/tagged_memory.sv
src/icache_top.sv
testbench/icache_properties.sv
testbench/icache_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the instruction cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module icache_tb \
  -f files.f \
  -o icache_sim

output=$(./obj_dir/icache_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qxF '>>> PASS'; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
